//--- project.f
+incdir+common
common/x25519_field_pkg.sv
common/x25519_bus_pkg.sv
ladder/x25519_select.sv
ladder/x25519_field_alu.sv
ladder/x25519_ladder.sv
src/x25519_axil_regs.sv
src/x25519_top.sv
sim/x25519_checker.sv
sim/x25519_tb.sv

//--- sim/x25519_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "x25519_settings.svh"

module x25519_tb;
	import x25519_field_pkg::*;
	import x25519_bus_pkg::*;

	localparam logic [511:0] PRIME = (512'd1 << 255) - 512'd19; // 2^255 - 19.
	localparam fe_t          A24_REF = 256'd121665;
	localparam fe_t          CLAMP_BITS = {1'b1, 252'b0, 3'b111}; // Bits the DUT overrides.
	localparam int           LIMIT = `TIMEOUT_CYCLES;

	logic      clk;
	logic      arst_n;
	axil_req_t req;
	axil_rsp_t rsp;
	integer    seed;
	longint    cyc = 0;  // Free-running cycle count.
	bit        bp_on;    // Random bready and rready stalls.

	x25519_top dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.s_axil_req (req),
		.s_axil_rsp (rsp)
	);

	bind x25519_top x25519_checker u_bus_chk (
		.clk(clk), .arst_n(arst_n), .req(s_axil_req), .rsp(s_axil_rsp),
		.en(1'b0), .out_valid(1'b0)
	);

	bind x25519_select x25519_checker u_sel_chk (
		.clk(clk), .arst_n(arst_n), .req('0), .rsp('0),
		.en(en), .out_valid(out_valid)
	);

	always #20 clk = ~clk; // 40 ns period.

	always @(posedge clk) cyc <= cyc + 1;

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		stop_failed();
	endtask

	// Bound checkers count their assertion failures.
	always @(negedge clk) begin
		if (dut.u_bus_chk.fails != 0 || dut.u_ladder.u_select.u_sel_chk.fails != 0) begin
			report_error("a bound assertion failed");
		end
	end

	task automatic check_fe(input string what, input fe_t got, input fe_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			report_mismatch($sformatf("%s response %b expected %b", what, got, exp));
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
	                          input logic [31:0] exp);
		if (got !== exp) begin
			report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	// Reference field arithmetic on values below p.
	function automatic fe_t add_mod(input fe_t a, input fe_t b);
		logic [511:0] s;
		s = a;
		s = (s + b) % PRIME;
		return s[255:0];
	endfunction

	function automatic fe_t sub_mod(input fe_t a, input fe_t b);
		logic [511:0] s;
		s = a;
		s = (s + PRIME - b) % PRIME;
		return s[255:0];
	endfunction

	function automatic fe_t mul_mod(input fe_t a, input fe_t b);
		logic [511:0] s;
		s = a;
		s = (s * b) % PRIME;
		return s[255:0];
	endfunction

	// RFC 7748 ladder on the clamped scalar with a projective result.
	function automatic void ref_x25519(input fe_t k_in, input fe_t u_in,
	                                   output fe_t x2_o, output fe_t z2_o);
		fe_t          k;
		fe_t          x1, x2, z2, x3, z3, tmp;
		fe_t          a, aa, b, bb, e, c, d, da, cb;
		logic         swap;
		logic         kt;
		logic [511:0] wide;
		k = k_in;
		k[2:0] = 3'b000;
		k[255] = 1'b0;
		k[254] = 1'b1;
		wide = u_in;
		wide[255] = 1'b0; // Masked, then reduced.
		wide = wide % PRIME;
		x1 = wide[255:0];
		x2 = 256'd1;
		z2 = '0;
		x3 = x1;
		z3 = 256'd1;
		swap = 1'b0;
		for (int t = 254; t >= 0; t--) begin
			kt = k[t];
			swap = swap ^ kt;
			if (swap) begin
				tmp = x2;
				x2 = x3;
				x3 = tmp;
				tmp = z2;
				z2 = z3;
				z3 = tmp;
			end
			swap = kt;
			a  = add_mod(x2, z2);
			aa = mul_mod(a, a);
			b  = sub_mod(x2, z2);
			bb = mul_mod(b, b);
			e  = sub_mod(aa, bb);
			c  = add_mod(x3, z3);
			d  = sub_mod(x3, z3);
			da = mul_mod(d, a);
			cb = mul_mod(c, b);
			x3 = mul_mod(add_mod(da, cb), add_mod(da, cb));
			z3 = mul_mod(x1, mul_mod(sub_mod(da, cb), sub_mod(da, cb)));
			x2 = mul_mod(aa, bb);
			z2 = mul_mod(e, add_mod(aa, mul_mod(A24_REF, e)));
		end
		if (swap) begin
			tmp = x2;
			x2 = x3;
			x3 = tmp;
			tmp = z2;
			z2 = z3;
			z3 = tmp;
		end
		x2_o = x2;
		z2_o = z2;
	endfunction

	// RFC test vectors list byte 0 first.
	function automatic fe_t from_le_bytes(input fe_t s);
		fe_t r;
		for (int i = 0; i < 32; i++) begin
			r[8*i +: 8] = s[255 - 8*i -: 8];
		end
		return r;
	endfunction

	function automatic fe_t rand_fe();
		fe_t r;
		for (int i = 0; i < 8; i++) begin
			r[32*i +: 32] = $random(seed);
		end
		return r;
	endfunction

	// Takes the B response, stalling bready first when enabled.
	task automatic accept_b(output logic [1:0] resp);
		int n;
		int hold;
		n = 0;
		hold = bp_on ? ($random(seed) & 7) : 0;
		@(negedge clk);
		while (!rsp.bvalid) begin
			n++;
			if (n > LIMIT) begin
				report_error("no write response from the DUT");
			end
			@(negedge clk);
		end
		resp = rsp.bresp;
		repeat (hold) begin
			@(negedge clk);
			if (!rsp.bvalid || rsp.bresp !== resp) begin
				report_mismatch("write response changed while bready was low");
			end
		end
		@(posedge clk);
		#2;
		req.bready = 1'b1;
		@(posedge clk); // Taken here.
		#2;
		req.bready = 1'b0;
	endtask

	task automatic accept_r(output logic [31:0] data, output logic [1:0] resp);
		int n;
		int hold;
		n = 0;
		hold = bp_on ? ($random(seed) & 7) : 0;
		@(negedge clk);
		while (!rsp.rvalid) begin
			n++;
			if (n > LIMIT) begin
				report_error("no read response from the DUT");
			end
			@(negedge clk);
		end
		data = rsp.rdata;
		resp = rsp.rresp;
		repeat (hold) begin
			@(negedge clk);
			if (!rsp.rvalid || rsp.rdata !== data || rsp.rresp !== resp) begin
				report_mismatch("read response changed while rready was low");
			end
		end
		@(posedge clk);
		#2;
		req.rready = 1'b1;
		@(posedge clk);
		#2;
		req.rready = 1'b0;
	endtask

	// Called and returns 2 ns after a rising edge.
	task automatic axil_write(input axil_addr_t addr, input logic [31:0] data,
	                          input logic [3:0] strb, output logic [1:0] resp);
		int n;
		n = 0;
		req.awaddr  = addr;
		req.awvalid = 1'b1;
		req.wdata   = data;
		req.wstrb   = strb;
		req.wvalid  = 1'b1;
		@(negedge clk);
		while (!(rsp.awready && rsp.wready)) begin
			n++;
			if (n > LIMIT) begin
				report_error("write address and data never accepted");
			end
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		accept_b(resp);
	endtask

	task automatic axil_read(input axil_addr_t addr, output logic [31:0] data,
	                         output logic [1:0] resp);
		int n;
		n = 0;
		req.araddr  = addr;
		req.arvalid = 1'b1;
		@(negedge clk);
		while (!rsp.arready) begin
			n++;
			if (n > LIMIT) begin
				report_error("read address never accepted");
			end
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		req.arvalid = 1'b0;
		accept_r(data, resp);
	endtask

	task automatic write_bank(input axil_addr_t base, input fe_t val);
		logic [1:0] resp;
		for (int i = 0; i < 8; i++) begin
			axil_write(axil_addr_t'(base + 4 * i), val[32*i +: 32], 4'hF, resp);
			check_resp("bank write", resp, RESP_OKAY);
		end
	endtask

	task automatic read_bank(input axil_addr_t base, output fe_t val);
		logic [31:0] data;
		logic [1:0]  resp;
		for (int i = 0; i < 8; i++) begin
			axil_read(axil_addr_t'(base + 4 * i), data, resp);
			check_resp("bank read", resp, RESP_OKAY);
			val[32*i +: 32] = data; // Word 0 least significant.
		end
	endtask

	task automatic load_operands(input fe_t k, input fe_t u);
		write_bank(REG_SCALAR, k);
		write_bank(REG_U, u);
	endtask

	task automatic start_run();
		logic [1:0] resp;
		axil_write(REG_CTRL, 32'h1, 4'hF, resp);
		check_resp("start write", resp, RESP_OKAY);
	endtask

	// Polls the done bit.
	task automatic wait_done();
		logic [31:0] status;
		logic [1:0]  resp;
		longint      t0;
		t0 = cyc;
		status = '0;
		while (!status[1]) begin
			if (cyc - t0 > LIMIT) begin
				report_error("ladder run did not finish within the cycle limit");
			end
			axil_read(REG_STATUS, status, resp);
			check_resp("status read", resp, RESP_OKAY);
		end
		check_word("busy after done", status & 32'h1, 32'h0);
	endtask

	task automatic finish_run(input fe_t k, input fe_t u);
		fe_t x2;
		fe_t z2;
		fe_t ex2;
		fe_t ez2;
		wait_done();
		read_bank(REG_X2, x2);
		read_bank(REG_Z2, z2);
		ref_x25519(k, u, ex2, ez2);
		check_fe("X2", x2, ex2);
		check_fe("Z2", z2, ez2);
	endtask

	task automatic run_case(input fe_t k, input fe_t u);
		load_operands(k, u);
		start_run();
		finish_run(k, u);
	endtask

	task automatic check_reg_map();
		fe_t         k;
		fe_t         uv;
		fe_t         got;
		logic [31:0] data;
		logic [31:0] old;
		logic [1:0]  resp;
		axil_addr_t  bad_rd [4] = '{8'h08, 8'h1C, 8'hA0, 8'hFC};
		axil_addr_t  ro_wr [4] = '{REG_STATUS, REG_X2, 8'h9C, 8'hC4};
		k = rand_fe();
		uv = rand_fe();
		load_operands(k, uv);
		read_bank(REG_SCALAR, got);
		check_fe("scalar readback", got, k); // Raw, not clamped.
		read_bank(REG_U, got);
		check_fe("u readback", got, uv);
		data = $random(seed);
		axil_write(REG_U + 8'h0C, data, 4'b0101, resp); // Bytes 0 and 2 of word 3.
		check_resp("strobed u write", resp, RESP_OKAY);
		uv[96 +: 8] = data[7:0];
		uv[112 +: 8] = data[23:16];
		read_bank(REG_U, got);
		check_fe("u after strobed write", got, uv);
		data = $random(seed);
		axil_write(REG_SCALAR + 8'h1C, data, 4'b1000, resp); // Top byte only.
		check_resp("strobed scalar write", resp, RESP_OKAY);
		k[248 +: 8] = data[31:24];
		read_bank(REG_SCALAR, got);
		check_fe("scalar after strobed write", got, k);
		foreach (bad_rd[i]) begin
			axil_read(bad_rd[i], data, resp);
			check_resp("unmapped read", resp, RESP_SLVERR);
			check_word("unmapped read data", data, 32'h0);
		end
		axil_read(REG_X2, old, resp);
		foreach (ro_wr[i]) begin
			axil_write(ro_wr[i], 32'hA5A5_5A5A, 4'hF, resp);
			check_resp("read-only write", resp, RESP_SLVERR);
		end
		axil_read(REG_X2, data, resp);
		check_word("X2 word 0 after write", data, old);
	endtask

	initial begin
		fe_t         k0;
		fe_t         u0;
		logic [31:0] data;
		logic [1:0]  resp;
		clk = 1'b0;
		arst_n = 1'b1;
		req = '0;
		seed = 18267;
		bp_on = 1'b0;
		#5;
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(posedge clk);
		#2;

		check_reg_map();
		bp_on = 1'b1; // Same map under back-pressure.
		check_reg_map();
		bp_on = 1'b0;

		// Operand lock while the ladder runs.
		k0 = rand_fe();
		u0 = rand_fe();
		load_operands(k0, u0);
		start_run();
		axil_read(REG_STATUS, data, resp);
		check_word("status during run", data & 32'h3, 32'h1);
		axil_write(REG_SCALAR, 32'hFFFF_FFFF, 4'hF, resp);
		check_resp("scalar write while busy", resp, RESP_SLVERR);
		axil_write(REG_U + 8'h04, 32'h0, 4'hF, resp);
		check_resp("u write while busy", resp, RESP_SLVERR);
		axil_write(REG_CTRL, 32'h1, 4'hF, resp);
		check_resp("start while busy", resp, RESP_SLVERR);
		axil_read(REG_SCALAR, data, resp);
		check_word("scalar word 0 kept", data, k0[31:0]);
		finish_run(k0, u0);

		// RFC 7748 first vector inputs, then random pairs.
		k0 = from_le_bytes(
			256'ha546e36b_f0527c9d_3b16154b_82465edd_62144c0a_c1fc5a18_506a2244_ba449ac4);
		u0 = from_le_bytes(
			256'he6db6867_583030db_3594c1a4_24b15f7c_726624ec_26b3353b_10a903a6_d0ab1c4c);
		run_case(k0, u0);
		for (int i = 0; i < 3; i++) begin
			bp_on = (i == 2); // Last one stalls responses.
			run_case(rand_fe(), rand_fe());
		end
		bp_on = 1'b0;

		// Clamped bits must not matter.
		k0 = rand_fe();
		u0 = rand_fe();
		run_case(k0, u0);
		load_operands(k0 ^ CLAMP_BITS, u0 ^ {1'b1, 255'b0});
		start_run();
		finish_run(k0, u0); // Expected from the original operands.

		if (dut.u_bus_chk.fails == 0 && dut.u_ladder.u_select.u_sel_chk.fails == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			report_error("bound checker reported assertion failures");
		end
	end

endmodule

`default_nettype wire

//--- sim/x25519_checker.sv
`timescale 1ns/10ps
`default_nettype none

module x25519_checker (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire x25519_bus_pkg::axil_req_t req,
	input  wire x25519_bus_pkg::axil_rsp_t rsp,
	input  wire                            en,
	input  wire                            out_valid
);
	int unsigned fails = 0; // Polled by the testbench.

	// Write response holds until bready.
	b_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
		else begin
			fails++;
			$error("write response dropped or changed before bready");
		end

	// Read response holds until rready.
	r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
		else begin
			fails++;
			$error("read response dropped or changed before rready");
		end

	// No response out of reset.
	rst_quiet: assert property (@(posedge clk) !arst_n |-> !rsp.bvalid && !rsp.rvalid)
		else begin
			fails++;
			$error("response valid while in reset");
		end

	sel_on: assert property (@(posedge clk) disable iff (!arst_n) en |=> out_valid)
		else begin
			fails++;
			$error("swap stage missed out_valid after en");
		end

	sel_off: assert property (@(posedge clk) disable iff (!arst_n) !en |=> !out_valid)
		else begin
			fails++;
			$error("swap stage raised out_valid without en");
		end

endmodule

`default_nettype wire

//--- src/x25519_top.sv
`timescale 1ns/10ps
`default_nettype none

module x25519_top (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire x25519_bus_pkg::axil_req_t s_axil_req,
	output x25519_bus_pkg::axil_rsp_t      s_axil_rsp
);
	import x25519_field_pkg::*;

	logic start;  // Pulse from a CTRL write.
	logic busy;
	logic done;   // Pulse at the end of a run.
	fe_t  scalar;
	fe_t  u;
	fe_t  x2;     // Projective result.
	fe_t  z2;

	x25519_axil_regs u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.s_axil_req (s_axil_req),
		.s_axil_rsp (s_axil_rsp),
		.start      (start),
		.scalar     (scalar),
		.u          (u),
		.busy       (busy),
		.done       (done),
		.x2         (x2),
		.z2         (z2)
	);

	x25519_ladder u_ladder (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.scalar (scalar),
		.u      (u),
		.busy   (busy),
		.done   (done),
		.x2     (x2),
		.z2     (z2)
	);

endmodule

`default_nettype wire

//--- src/x25519_axil_regs.sv
`timescale 1ns/10ps
`default_nettype none

module x25519_axil_regs (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire x25519_bus_pkg::axil_req_t s_axil_req,
	output x25519_bus_pkg::axil_rsp_t      s_axil_rsp,
	output logic                           start,
	output x25519_field_pkg::fe_t          scalar,
	output x25519_field_pkg::fe_t          u,
	input  wire                            busy,
	input  wire                            done,
	input  wire x25519_field_pkg::fe_t     x2,
	input  wire x25519_field_pkg::fe_t     z2
);
	import x25519_field_pkg::*;
	import x25519_bus_pkg::*;

	logic        wr_fire;
	logic        rd_fire;
	logic        bvalid;
	logic        rvalid;
	logic [1:0]  bresp;
	logic [1:0]  rresp;
	logic [31:0] rdata;
	logic [1:0]  wr_resp;
	logic [1:0]  rd_resp;
	logic [31:0] rd_data;
	logic [2:0]  wr_word;
	logic [2:0]  rd_word;
	logic        wr_scalar;
	logic        wr_u;
	logic        wr_ctrl;
	logic        done_q;   // Sticky, cleared by start.
	fe_t         x2_q;
	fe_t         z2_q;

	// Merge one word into a bank under byte strobes.
	function automatic fe_t put_word(input fe_t cur, input logic [2:0] word,
	                                 input logic [31:0] data, input logic [3:0] strb);
		fe_t nxt;
		nxt = cur;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				nxt[word*32 + i*8 +: 8] = data[i*8 +: 8];
			end
		end
		return nxt;
	endfunction

	// AW and W are taken together, one response outstanding.
	assign wr_fire   = s_axil_req.awvalid && s_axil_req.wvalid && !bvalid;
	assign rd_fire   = s_axil_req.arvalid && !rvalid;
	assign wr_word   = s_axil_req.awaddr[4:2];
	assign rd_word   = s_axil_req.araddr[4:2];
	assign wr_scalar = s_axil_req.awaddr[7:5] == REG_SCALAR[7:5];
	assign wr_u      = s_axil_req.awaddr[7:5] == REG_U[7:5];
	assign wr_ctrl   = s_axil_req.awaddr == REG_CTRL;

	// Operands and control are locked while a run is active.
	assign wr_resp = ((wr_scalar || wr_u || wr_ctrl) && !busy) ? RESP_OKAY : RESP_SLVERR;
	assign start   = wr_fire && wr_ctrl && !busy && s_axil_req.wstrb[0] && s_axil_req.wdata[0];

	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (s_axil_req.araddr[7:5])
			REG_CTRL[7:5]: begin
				if (s_axil_req.araddr == REG_STATUS) begin
					rd_data = {30'b0, done_q, busy};
				end else if (s_axil_req.araddr != REG_CTRL) begin
					rd_resp = RESP_SLVERR; // Hole in the control page.
				end
			end
			REG_SCALAR[7:5]: rd_data = scalar[rd_word*32 +: 32];
			REG_U[7:5]:      rd_data = u[rd_word*32 +: 32];
			REG_X2[7:5]:     rd_data = x2_q[rd_word*32 +: 32];
			REG_Z2[7:5]:     rd_data = z2_q[rd_word*32 +: 32];
			default:         rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			done_q <= 1'b0;
			scalar <= '0;
			u      <= '0;
			x2_q   <= '0;
			z2_q   <= '0;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				if (wr_scalar && !busy) begin
					scalar <= put_word(scalar, wr_word, s_axil_req.wdata, s_axil_req.wstrb);
				end
				if (wr_u && !busy) begin
					u <= put_word(u, wr_word, s_axil_req.wdata, s_axil_req.wstrb);
				end
			end else if (s_axil_req.bready) begin
				bvalid <= 1'b0;
			end
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (s_axil_req.rready) begin
				rvalid <= 1'b0;
			end
			if (start) begin
				done_q <= 1'b0;
			end else if (done) begin
				done_q <= 1'b1;
				x2_q   <= x2; // Results stay until the next run ends.
				z2_q   <= z2;
			end
		end
	end

	// Response payloads change only on acceptance.
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= wr_resp;
		end
		if (rd_fire) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	always_comb begin
		s_axil_rsp.awready = wr_fire;
		s_axil_rsp.wready  = wr_fire;
		s_axil_rsp.bresp   = bresp;
		s_axil_rsp.bvalid  = bvalid;
		s_axil_rsp.arready = !rvalid;
		s_axil_rsp.rdata   = rdata;
		s_axil_rsp.rresp   = rresp;
		s_axil_rsp.rvalid  = rvalid;
	end

endmodule

`default_nettype wire

//--- ladder/x25519_ladder.sv
`timescale 1ns/10ps
`default_nettype none

module x25519_ladder (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        start,
	input  wire x25519_field_pkg::fe_t scalar,
	input  wire x25519_field_pkg::fe_t u,
	output logic                       busy,
	output logic                       done,
	output x25519_field_pkg::fe_t      x2,
	output x25519_field_pkg::fe_t      z2
);
	import x25519_field_pkg::*;

	typedef enum logic [3:0] {
		R_X2, R_Z2, R_X3, R_Z3,            // Ladder state.
		R_X1, R_A24,                       // Base u and curve constant.
		R_T0, R_T1, R_T2, R_T3, R_T4, R_T5 // Step temporaries.
	} slot_e;

	typedef struct packed {
		alu_op_e op;
		slot_e   dst;
		slot_e   sa;
		slot_e   sb;
	} uop_t;

	typedef enum logic [1:0] {S_IDLE, S_SWAP, S_OP, S_WAIT} state_e;

	localparam logic [4:0] LAST_UOP = 5'd17;

	state_e     state;
	fe_t        rf [12];
	fe_t        k_sh;    // Clamped scalar, current bit at 254.
	fe_t        k_clamp;
	fe_t        u_mask;
	fe_t        u_red;
	logic [7:0] bit_cnt; // Scalar bit in progress.
	logic [4:0] pc;      // Microcode index.
	logic [1:0] sw_cnt;  // 0 issue X, 1 issue Z, 2 last capture.
	logic       swap;    // Previous scalar bit.
	logic       fin;     // Final swap pending.
	uop_t       uop;
	logic       sel_en;
	logic       sel_b;
	logic       sel_valid;
	fe_t        sel_r;
	fe_t        sel_s;
	fe_t        sel_p;
	fe_t        sel_q;
	logic       alu_start;
	logic       alu_done;
	alu_req_t   alu_req;
	alu_rsp_t   alu_rsp;

	// RFC 7748 ladder step.
	function automatic uop_t ucode(input logic [4:0] idx);
		uop_t w;
		case (idx)
			5'd0:    w = '{ALU_ADD, R_T0, R_X2, R_Z2};  // A.
			5'd1:    w = '{ALU_MUL, R_T1, R_T0, R_T0};  // AA.
			5'd2:    w = '{ALU_SUB, R_T2, R_X2, R_Z2};  // B.
			5'd3:    w = '{ALU_MUL, R_T3, R_T2, R_T2};  // BB.
			5'd4:    w = '{ALU_SUB, R_T4, R_T1, R_T3};  // E.
			5'd5:    w = '{ALU_ADD, R_T5, R_X3, R_Z3};  // C.
			5'd6:    w = '{ALU_SUB, R_X3, R_X3, R_Z3};  // D, x3 is dead.
			5'd7:    w = '{ALU_MUL, R_Z3, R_X3, R_T0};  // DA.
			5'd8:    w = '{ALU_MUL, R_T0, R_T5, R_T2};  // CB.
			5'd9:    w = '{ALU_ADD, R_X3, R_Z3, R_T0};  // DA + CB.
			5'd10:   w = '{ALU_MUL, R_X3, R_X3, R_X3};  // New x3.
			5'd11:   w = '{ALU_SUB, R_Z3, R_Z3, R_T0};  // DA - CB.
			5'd12:   w = '{ALU_MUL, R_Z3, R_Z3, R_Z3};
			5'd13:   w = '{ALU_MUL, R_Z3, R_X1, R_Z3};  // New z3.
			5'd14:   w = '{ALU_MUL, R_X2, R_T1, R_T3};  // New x2.
			5'd15:   w = '{ALU_MUL, R_T2, R_A24, R_T4}; // a24 * E.
			5'd16:   w = '{ALU_ADD, R_T2, R_T1, R_T2};  // AA + a24 * E.
			default: w = '{ALU_MUL, R_Z2, R_T4, R_T2};  // New z2.
		endcase
		return w;
	endfunction

	assign k_clamp = {2'b01, scalar[253:3], 3'b000};
	assign u_mask  = {1'b0, u[254:0]};
	assign u_red   = (u_mask >= FIELD_P) ? u_mask - FIELD_P : u_mask; // Non-canonical u.

	// X pair on the first swap cycle, Z pair on the second.
	assign sel_en = (state == S_SWAP) && (sw_cnt != 2'd2);
	assign sel_b  = swap ^ (k_sh[254] & ~fin); // Final swap uses the last bit alone.
	assign sel_r  = sw_cnt[0] ? rf[R_Z2] : rf[R_X2];
	assign sel_s  = sw_cnt[0] ? rf[R_Z3] : rf[R_X3];

	assign uop       = ucode(pc);
	assign alu_start = (state == S_OP);
	assign alu_req   = '{op: uop.op, a: rf[uop.sa], b: rf[uop.sb]};

	assign x2 = rf[R_X2];
	assign z2 = rf[R_Z2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= S_IDLE;
			busy    <= 1'b0;
			done    <= 1'b0;
			bit_cnt <= '0;
			pc      <= '0;
			sw_cnt  <= '0;
			swap    <= 1'b0;
			fin     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						busy    <= 1'b1;
						swap    <= 1'b0;
						fin     <= 1'b0;
						bit_cnt <= 8'd254;
						pc      <= '0;
						sw_cnt  <= '0;
						state   <= S_SWAP;
					end
				end
				S_SWAP: begin
					sw_cnt <= sw_cnt + 1'b1;
					if (sw_cnt == 2'd2) begin // Z pair lands this cycle.
						sw_cnt <= '0;
						swap   <= k_sh[254];
						if (fin) begin
							busy  <= 1'b0;
							done  <= 1'b1;
							state <= S_IDLE;
						end else begin
							state <= S_OP;
						end
					end
				end
				S_OP: state <= S_WAIT;
				S_WAIT: begin
					if (alu_done) begin
						if (pc == LAST_UOP) begin
							pc      <= '0;
							bit_cnt <= bit_cnt - 1'b1;
							fin     <= (bit_cnt == 8'd0); // Bit 0 just finished.
							state   <= S_SWAP;
						end else begin
							pc    <= pc + 1'b1;
							state <= S_OP;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && start) begin
			rf[R_X2]  <= 256'd1;
			rf[R_Z2]  <= '0;
			rf[R_X3]  <= u_red;
			rf[R_Z3]  <= 256'd1;
			rf[R_X1]  <= u_red;
			rf[R_A24] <= A24;
			k_sh      <= k_clamp;
		end
		if (sel_valid) begin
			if (sw_cnt[1]) begin
				rf[R_Z2] <= sel_p;
				rf[R_Z3] <= sel_q;
			end else begin
				rf[R_X2] <= sel_p;
				rf[R_X3] <= sel_q;
			end
		end
		if (state == S_WAIT && alu_done) begin
			rf[uop.dst] <= alu_rsp.result;
			if (pc == LAST_UOP) begin
				k_sh <= k_sh << 1; // Next bit.
			end
		end
	end

	x25519_select u_select (
		.clk       (clk),
		.arst_n    (arst_n),
		.en        (sel_en),
		.b         (sel_b),
		.r         (sel_r),
		.s         (sel_s),
		.p         (sel_p),
		.q         (sel_q),
		.out_valid (sel_valid)
	);

	x25519_field_alu u_alu (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (alu_start),
		.req    (alu_req),
		.done   (alu_done),
		.rsp    (alu_rsp)
	);

endmodule

`default_nettype wire

//--- ladder/x25519_field_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "x25519_settings.svh"

module x25519_field_alu (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            start,
	input  wire x25519_field_pkg::alu_req_t req,
	output logic                           done,
	output x25519_field_pkg::alu_rsp_t     rsp
);
	import x25519_field_pkg::*;

	localparam int DIG  = `MUL_DIGIT_BITS;
	localparam int NDIG = 256 / DIG;
	localparam int TW   = 256 + DIG + 1; // Shifted accumulator plus partial product.

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL,  // Digit steps 2 to NDIG.
		ST_FOLD, // Fold bit 255.
		ST_FIN   // Final conditional subtract.
	} state_e;

	state_e                  state;
	logic [$clog2(NDIG)-1:0] cnt;      // Digits consumed so far.
	logic                    ld;       // Accepted request.
	fe_t                     a_q;
	fe_t                     b_q;      // Remaining digits, top aligned.
	fe_t                     acc;      // Partially reduced, below 2^256.
	fe_t                     red;      // Below 2p.
	fe_t                     a_in;
	fe_t                     b_in;
	fe_t                     acc_in;
	logic [DIG-1:0]          dig;
	logic [255+DIG:0]        part;     // a times one digit.
	logic [TW-1:0]           t_sum;
	logic [DIG+1:0]          t_hi;     // Bits 255 and up of t_sum.
	fe_t                     acc_nxt;
	fe_t                     red_nxt;
	fe_t                     red_fold;

	assign ld = start && (state == ST_IDLE);

	// The first digit step runs on the request itself.
	assign a_in   = ld ? req.a : a_q;
	assign b_in   = ld ? req.b : b_q;
	assign acc_in = ld ? '0 : acc;
	assign dig    = b_in[255 -: DIG]; // Top digit first.

	// acc * 2^DIG + a * digit, then 2^255 = 19 mod p.
	assign part    = a_in * dig;
	assign t_sum   = {1'b0, acc_in, {DIG{1'b0}}} + {1'b0, part};
	assign t_hi    = t_sum[TW-1:255];
	assign acc_nxt = {1'b0, t_sum[254:0]} + t_hi * 256'd19; // Stays below 2^256.

	// Inputs are canonical, so both sums are below 2p.
	always_comb begin
		case (req.op)
			ALU_ADD: red_nxt = req.a + req.b;
			ALU_SUB: red_nxt = req.a + FIELD_P - req.b; // Never negative.
			default: red_nxt = '0;                      // Multiply fills red later.
		endcase
	end

	// acc below 2^256 folds to below 2^255 + 19.
	assign red_fold = {1'b0, acc[254:0]} + (acc[255] ? 256'd19 : 256'd0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			cnt   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						cnt   <= 'd1;
						state <= (req.op == ALU_MUL) ? ST_MUL : ST_FIN;
					end
				end
				ST_MUL: begin
					cnt <= cnt + 1'b1;
					if (cnt == NDIG - 1) begin
						state <= ST_FOLD; // Last digit this cycle.
					end
				end
				ST_FOLD: state <= ST_FIN;
				ST_FIN: begin
					done  <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ld) begin
			a_q <= req.a;
			b_q <= req.b << DIG;
			acc <= acc_nxt;
			red <= red_nxt;
		end
		if (state == ST_MUL) begin
			b_q <= b_q << DIG;
			acc <= acc_nxt;
		end
		if (state == ST_FOLD) begin
			red <= red_fold;
		end
		if (state == ST_FIN) begin
			rsp.result <= (red >= FIELD_P) ? red - FIELD_P : red; // Canonical.
		end
	end

endmodule

`default_nettype wire

//--- ladder/x25519_select.sv
`timescale 1ns/10ps
`default_nettype none

module x25519_select (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        en,
	input  wire                        b,
	input  wire x25519_field_pkg::fe_t r,
	input  wire x25519_field_pkg::fe_t s,
	output x25519_field_pkg::fe_t      p,
	output x25519_field_pkg::fe_t      q,
	output logic                       out_valid
);
	import x25519_field_pkg::*;

	fe_t mask; // All ones when swapping.

	// Same logic depth for either value of b.
	assign mask = {$bits(fe_t){b}};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= en; // One cycle behind en.
		end
	end

	// Outputs hold between enables.
	always_ff @(posedge clk) begin
		if (en) begin
			p <= (r & ~mask) | (s & mask); // s when swapped.
			q <= (s & ~mask) | (r & mask); // r when swapped.
		end
	end

endmodule

`default_nettype wire

//--- common/x25519_bus_pkg.sv
`default_nettype none

`include "x25519_settings.svh"

package x25519_bus_pkg;

	typedef logic [`AXI_ADDR_BITS-1:0] axil_addr_t;

	// Manager to subordinate.
	typedef struct packed {
		axil_addr_t  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		axil_addr_t  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// Subordinate to manager.
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register map. Banks hold 8 words, word 0 least significant.
	localparam axil_addr_t REG_CTRL   = 8'h00; // Bit 0 starts a run.
	localparam axil_addr_t REG_STATUS = 8'h04; // Bit 0 busy, bit 1 done.
	localparam axil_addr_t REG_SCALAR = 8'h20; // Scalar bank, raw.
	localparam axil_addr_t REG_U      = 8'h40; // u-coordinate bank, raw.
	localparam axil_addr_t REG_X2     = 8'h60; // Result X2, read only.
	localparam axil_addr_t REG_Z2     = 8'h80; // Result Z2, read only.

endpackage

`default_nettype wire

//--- common/x25519_field_pkg.sv
`default_nettype none

package x25519_field_pkg;

	// Field element mod p. ALU results are always below p.
	typedef logic [255:0] fe_t;

	// p = 2^255 - 19.
	localparam fe_t FIELD_P =
		256'h7FFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFED;

	// (486662 - 2) / 4, ladder step constant.
	localparam fe_t A24 = 256'd121665;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0, // a + b mod p.
		ALU_SUB = 2'd1, // a - b mod p.
		ALU_MUL = 2'd2  // a * b mod p.
	} alu_op_e;

	// One ALU operation.
	typedef struct packed {
		alu_op_e op;
		fe_t     a;
		fe_t     b;
	} alu_req_t;

	// Canonical result.
	typedef struct packed {
		fe_t result;
	} alu_rsp_t;

endpackage

`default_nettype wire

//--- common/x25519_settings.svh
`ifndef X25519_SETTINGS_SVH
`define X25519_SETTINGS_SVH

// Bits of multiplier operand b consumed per cycle.
// 256 must be a multiple of this.
`define MUL_DIGIT_BITS 16

// AXI4-Lite address width. The map needs 8 bits.
`define AXI_ADDR_BITS 8

// Cycle limit for handshake waits and status polling.
`define TIMEOUT_CYCLES 200000

`endif
